/* build.f */
+incdir+source
source/video_pkg.sv
source/mode_select.sv
source/raster_counter.sv
source/sync_output.sv
source/video_timing_top.sv
tb/tb_video_timing.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_video_timing \
	-Mdir obj_dir -o sim_video_timing > sim.log 2>&1 \
	&& ./obj_dir/sim_video_timing >> sim.log 2>&1
cat sim.log
! grep -q "Test failures found" sim.log && grep -q "All tests passed!" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* tb/tb_video_timing.sv */
`timescale 1ns/1ps
`include "video_settings.svh"

module tb_video_timing;

	logic              clk50m_bufg;
	logic              arst_n;
	logic [3:0]        sw;
	logic              hsync;
	logic              vsync;
	logic              de;
	logic [`CNT_W-1:0] hcount;
	logic [`CNT_W-1:0] vcount;
	logic [3:0]        mode;

	integer     seed;          // $random state
	string      test_name;
	int         px_in_mode;    // Pixels checked since the last restart
	int         warm;          // Samples since reset release
	int         prev_h;
	int         prev_v;
	logic [3:0] mode_h [5];    // Sampled mode history with newest first

	video_timing_top dut0 (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount      (hcount),
		.vcount      (vcount),
		.mode        (mode)
	);

	always #10 clk50m_bufg = ~clk50m_bufg;   // 50 MHz

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	// Horizontal values at 0 to 3, vertical at 4 to 7 and polarity at 8
	function automatic int mode_param(input logic [3:0] m, input int sel);
		int p [9];
		case (m)
			`MODE_VGA: p = '{`H_PIXELS_VGA, `H_FPORCH_VGA, `H_SYNC_VGA, `H_BPORCH_VGA,
				`V_LINES_VGA, `V_FPORCH_VGA, `V_SYNC_VGA, `V_BPORCH_VGA, int'(`POL_NEG_VGA)};
			`MODE_SVGA: p = '{`H_PIXELS_SVGA, `H_FPORCH_SVGA, `H_SYNC_SVGA, `H_BPORCH_SVGA,
				`V_LINES_SVGA, `V_FPORCH_SVGA, `V_SYNC_SVGA, `V_BPORCH_SVGA,
				int'(`POL_NEG_SVGA)};
			`MODE_XGA: p = '{`H_PIXELS_XGA, `H_FPORCH_XGA, `H_SYNC_XGA, `H_BPORCH_XGA,
				`V_LINES_XGA, `V_FPORCH_XGA, `V_SYNC_XGA, `V_BPORCH_XGA, int'(`POL_NEG_XGA)};
			`MODE_SXGA: p = '{`H_PIXELS_SXGA, `H_FPORCH_SXGA, `H_SYNC_SXGA, `H_BPORCH_SXGA,
				`V_LINES_SXGA, `V_FPORCH_SXGA, `V_SYNC_SXGA, `V_BPORCH_SXGA,
				int'(`POL_NEG_SXGA)};
			`MODE_CAMERA: p = '{`H_PIXELS_CAMERA, `H_FPORCH_CAMERA, `H_SYNC_CAMERA,
				`H_BPORCH_CAMERA, `V_LINES_CAMERA, `V_FPORCH_CAMERA, `V_SYNC_CAMERA,
				`V_BPORCH_CAMERA, int'(`POL_NEG_CAMERA)};
			default: p = '{`H_PIXELS_HD720, `H_FPORCH_HD720, `H_SYNC_HD720, `H_BPORCH_HD720,
				`V_LINES_HD720, `V_FPORCH_HD720, `V_SYNC_HD720, `V_BPORCH_HD720,
				int'(`POL_NEG_HD720)};   // Unlisted codes fall back to 720p
		endcase
		return p[sel];
	endfunction

	function automatic int line_len(input logic [3:0] m);
		return mode_param(m, 0) + mode_param(m, 1) + mode_param(m, 2) + mode_param(m, 3);
	endfunction

	function automatic int frame_lines(input logic [3:0] m);
		return mode_param(m, 4) + mode_param(m, 5) + mode_param(m, 6) + mode_param(m, 7);
	endfunction

	function automatic int frame_len(input logic [3:0] m);
		return line_len(m) * frame_lines(m);
	endfunction

	// Expected {de, hsync, vsync} for one pixel
	function automatic logic [2:0] expected_outputs(input logic [3:0] m, input int h,
		input int v);
		int   hs_first;
		int   vs_first;
		logic h_in;
		logic v_in;
		logic neg;
		hs_first = mode_param(m, 0) + mode_param(m, 1) - 1;   // Porch counted from last visible
		vs_first = mode_param(m, 4) + mode_param(m, 5) - 1;
		h_in     = (h >= hs_first) && (h < hs_first + mode_param(m, 2));
		v_in     = (v >= vs_first) && (v < vs_first + mode_param(m, 6));
		neg      = (mode_param(m, 8) != 0);
		return {(h < mode_param(m, 0)) && (v < mode_param(m, 4)), h_in ^ neg, v_in ^ neg};
	endfunction

	////////////////////////////////////////
	// Check helpers
	////////////////////////////////////////
	task automatic stop_on_failure();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic wait_pixels(input int n);
		while (px_in_mode < n) begin
			@(negedge clk50m_bufg);
		end
	endtask

	// Moves the switches and waits for the mode to follow
	task automatic switch_mode(input logic [3:0] code);
		int n;
		sw = code;
		n  = 0;
		while (mode !== code && n < `DEBOUNCE_CYCLES + 5) begin
			@(negedge clk50m_bufg);
			n++;
		end
		if (mode !== code) begin
			$display("Mode %b was not taken within %0d cycles of a stable switch change",
				code, n);
			stop_on_failure();
		end
		repeat (4) @(negedge clk50m_bufg);   // Restart reaches the outputs
	endtask

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////
	// Outputs lag the sampled mode by three edges
	always @(posedge clk50m_bufg) begin
		logic [2:0] exp_lvl;
		logic [3:0] ref_m;
		int         exp_h;
		int         exp_v;
		if (!arst_n) begin
			warm       = 0;
			px_in_mode = 0;
			prev_h     = 0;
			prev_v     = 0;
			mode_h     = '{default: `MODE_VGA};
		end else begin
			for (int i = 4; i > 0; i--) begin
				mode_h[i] = mode_h[i - 1];
			end
			mode_h[0] = mode;
			ref_m     = mode_h[3];                           // Mode behind the output pixel
			if (warm >= 2) begin                             // Pipe bubble skipped
				exp_lvl = expected_outputs(ref_m, int'(hcount), int'(vcount));
				check_value("de", exp_lvl[2], de);
				check_value("hsync", exp_lvl[1], hsync);
				check_value("vsync", exp_lvl[0], vsync);
				px_in_mode++;
			end
			if (mode_h[3] != mode_h[4]) begin
				check_value("hcount after restart", 0, hcount);
				check_value("vcount after restart", 0, vcount);
				px_in_mode = 1;
			end else if (warm >= 3) begin
				exp_h = (prev_h == line_len(ref_m) - 1) ? 0 : prev_h + 1;
				exp_v = prev_v;
				if (exp_h == 0) begin
					exp_v = (prev_v == frame_lines(ref_m) - 1) ? 0 : prev_v + 1;
				end
				check_value("hcount", exp_h, hcount);
				check_value("vcount", exp_v, vcount);
			end
			prev_h = int'(hcount);
			prev_v = int'(vcount);
			if (warm < 3) begin
				warm++;
			end
		end
	end

	// Watchdog sized from the frame and line counts of all tests
	initial begin
		longint cycles;
		cycles = longint'(frame_len(`MODE_VGA)) + frame_len(`MODE_SVGA) + frame_len(4'b1111)
			+ 3 * (line_len(`MODE_XGA) + line_len(`MODE_SXGA) + line_len(`MODE_CAMERA))
			+ 3 * (2 * `DEBOUNCE_CYCLES + 8) + 5 * (`DEBOUNCE_CYCLES + 9) + 100;
		#(cycles * 22);                                      // 20 ns plus 10 percent
		$display("Watchdog expired after %0d ns, the run did not finish in time", cycles * 22);
		stop_on_failure();
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		int         glen;
		int         j;
		logic [3:0] tmp;
		logic [3:0] extra [3];
		seed        = 6;
		clk50m_bufg = 1'b0;
		arst_n      = 1'b0;
		sw          = `MODE_VGA;
		test_name   = "reset_state";
		extra       = '{`MODE_XGA, `MODE_SXGA, `MODE_CAMERA};
		repeat (4) @(posedge clk50m_bufg);
		@(negedge clk50m_bufg);
		check_value("mode", `MODE_VGA, mode);
		check_value("de", 0, de);
		check_value("hsync", 1, hsync);      // VGA idle level
		check_value("vsync", 1, vsync);
		check_value("hcount", 0, hcount);
		check_value("vcount", 0, vcount);
		arst_n = 1'b1;

		test_name = "vga_frame";                      // Negative polarity
		wait_pixels(frame_len(`MODE_VGA));

		// Short pulses on the switches
		test_name = "glitch";
		repeat (3) begin
			glen = 1 + int'($unsigned($random(seed)) % (`DEBOUNCE_CYCLES - 1));
			sw   = `MODE_SVGA;
			repeat (glen) @(negedge clk50m_bufg);
			sw = `MODE_VGA;
			repeat (`DEBOUNCE_CYCLES + 8) begin
				@(negedge clk50m_bufg);
				check_value("mode", `MODE_VGA, mode);
			end
		end

		test_name = "svga_frame";                     // Positive polarity
		switch_mode(`MODE_SVGA);
		wait_pixels(frame_len(`MODE_SVGA));

		test_name = "default_720p";
		switch_mode(4'b1111);
		wait_pixels(frame_len(4'b1111));

		// Remaining table entries in shuffled order
		test_name = "other_modes";
		for (int i = 2; i > 0; i--) begin
			j        = int'($unsigned($random(seed)) % (i + 1));
			tmp      = extra[i];
			extra[i] = extra[j];
			extra[j] = tmp;
		end
		for (int i = 0; i < 3; i++) begin
			switch_mode(extra[i]);
			wait_pixels(3 * line_len(extra[i]));
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

/* source/video_timing_top.sv */
`timescale 1ns/1ps
`include "video_settings.svh"

module video_timing_top (
	input  logic                  clk50m_bufg,
	input  logic                  arst_n,
	input  logic [3:0]            sw,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  de,
	output logic [`CNT_W-1:0]     hcount,
	output logic [`CNT_W-1:0]     vcount,
	output video_pkg::mode_code_t mode
);
	import video_pkg::*;

	raster_timing_t    timing;
	logic              restart;
	logic [`CNT_W-1:0] rc_hcount;   // Raster stage counts
	logic [`CNT_W-1:0] rc_vcount;
	logic              rc_h_active;
	logic              rc_v_active;
	logic              rc_h_sync;
	logic              rc_v_sync;
	logic              rc_neg_pol;

	////////////////////////////////////////
	// Mode, raster, output
	////////////////////////////////////////
	mode_select u_mode_select (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.sw          (sw),
		.mode        (mode),
		.timing      (timing),
		.restart     (restart)
	);

	raster_counter u_raster_counter (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.timing      (timing),
		.restart     (restart),
		.hcount      (rc_hcount),
		.vcount      (rc_vcount),
		.h_active    (rc_h_active),
		.v_active    (rc_v_active),
		.h_sync      (rc_h_sync),
		.v_sync      (rc_v_sync),
		.neg_pol     (rc_neg_pol)
	);

	sync_output u_sync_output (
		.clk50m_bufg (clk50m_bufg),
		.arst_n      (arst_n),
		.hcount      (rc_hcount),
		.vcount      (rc_vcount),
		.h_active    (rc_h_active),
		.v_active    (rc_v_active),
		.h_sync      (rc_h_sync),
		.v_sync      (rc_v_sync),
		.neg_pol     (rc_neg_pol),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount_o    (hcount),
		.vcount_o    (vcount)
	);

endmodule

/* source/sync_output.sv */
`timescale 1ns/1ps
`include "video_settings.svh"

module sync_output (
	input  logic              clk50m_bufg,
	input  logic              arst_n,
	input  logic [`CNT_W-1:0] hcount,
	input  logic [`CNT_W-1:0] vcount,
	input  logic              h_active,
	input  logic              v_active,
	input  logic              h_sync,
	input  logic              v_sync,
	input  logic              neg_pol,
	output logic              hsync,
	output logic              vsync,
	output logic              de,
	output logic [`CNT_W-1:0] hcount_o,
	output logic [`CNT_W-1:0] vcount_o
);

	logic [`CNT_W-1:0] hcount_d1;
	logic [`CNT_W-1:0] vcount_d1;
	logic              hsync_d1;
	logic              vsync_d1;
	logic              de_d1;

	////////////////////////////////////////
	// Two-stage output pipe
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			hcount_d1 <= '0;
			vcount_d1 <= '0;
			hsync_d1  <= `POL_NEG_VGA;            // Idle level for VGA
			vsync_d1  <= `POL_NEG_VGA;
			de_d1     <= 1'b0;
			hcount_o  <= '0;
			vcount_o  <= '0;
			hsync     <= `POL_NEG_VGA;
			vsync     <= `POL_NEG_VGA;
			de        <= 1'b0;
		end else begin
			hcount_d1 <= hcount;
			vcount_d1 <= vcount;
			hsync_d1  <= h_sync ^ neg_pol;        // Low when active and negative
			vsync_d1  <= v_sync ^ neg_pol;
			de_d1     <= h_active & v_active;
			hcount_o  <= hcount_d1;
			vcount_o  <= vcount_d1;
			hsync     <= hsync_d1;
			vsync     <= vsync_d1;
			de        <= de_d1;
		end
	end

	// No hsync pulse inside the visible area
	a_de_outside_hsync : assert property (
		@(posedge clk50m_bufg) disable iff (!arst_n)
		de |-> (hsync == $past(neg_pol, 2))
	);

endmodule

/* source/raster_counter.sv */
`timescale 1ns/1ps
`include "video_settings.svh"

module raster_counter (
	input  logic                      clk50m_bufg,
	input  logic                      arst_n,
	input  video_pkg::raster_timing_t timing,
	input  logic                      restart,
	output logic [`CNT_W-1:0]         hcount,
	output logic [`CNT_W-1:0]         vcount,
	output logic                      h_active,
	output logic                      v_active,
	output logic                      h_sync,
	output logic                      v_sync,
	output logic                      neg_pol
);

	logic [`CNT_W-1:0] h_next;
	logic [`CNT_W-1:0] v_next;
	logic              h_wrap;   // Last pixel of the line
	logic              v_wrap;   // Last line of the frame

	assign h_wrap = (hcount == timing.h_last);
	assign v_wrap = (vcount == timing.v_last);

	////////////////////////////////////////
	// Next count
	////////////////////////////////////////
	always_comb begin
		if (restart) begin
			h_next = '0;
			v_next = '0;
		end else begin
			h_next = h_wrap ? '0 : hcount + 1'b1;
			v_next = vcount;                               // Lines step only on wrap
			if (h_wrap) begin
				v_next = v_wrap ? '0 : vcount + 1'b1;
			end
		end
	end

	// Flags decoded from the next count so they leave with it
	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			hcount   <= '0;
			vcount   <= '0;
			h_active <= 1'b1;          // Pixel 0 of VGA is visible
			v_active <= 1'b1;
			h_sync   <= 1'b0;
			v_sync   <= 1'b0;
			neg_pol  <= `POL_NEG_VGA;
		end else begin
			hcount   <= h_next;
			vcount   <= v_next;
			h_active <= (h_next <= timing.h_act_last);
			v_active <= (v_next <= timing.v_act_last);
			h_sync   <= (h_next >= timing.h_sync_start) && (h_next < timing.h_sync_stop);
			v_sync   <= (v_next >= timing.v_sync_start) && (v_next < timing.v_sync_stop);
			neg_pol  <= timing.neg_pol;                    // Follows the pixel
		end
	end

	// Old counts may sit past new thresholds only while restart is high
	a_count_in_range : assert property (
		@(posedge clk50m_bufg) disable iff (!arst_n)
		!restart |-> (hcount <= timing.h_last) && (vcount <= timing.v_last)
	);

endmodule

/* source/mode_select.sv */
`timescale 1ns/1ps
`include "video_settings.svh"

module mode_select (
	input  logic                      clk50m_bufg,
	input  logic                      arst_n,
	input  logic [3:0]                sw,
	output video_pkg::mode_code_t     mode,
	output video_pkg::raster_timing_t timing,
	output logic                      restart
);
	import video_pkg::*;

	localparam int DB_W = $clog2(`DEBOUNCE_CYCLES);

	mode_code_t      sw_meta;    // First synchronizer flop
	mode_code_t      sw_sync;    // Second synchronizer flop
	mode_code_t      sw_q;       // Registered code under test
	mode_code_t      code_acc;   // Code that passed the debounce
	logic [DB_W-1:0] db_cnt;
	logic            db_run;
	logic            accept;     // One cycle when debounce completes

	////////////////////////////////////////
	// Switch synchronizer
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			sw_meta <= `MODE_VGA;
			sw_sync <= `MODE_VGA;
			sw_q    <= `MODE_VGA;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_q    <= sw_sync;
		end
	end

	// New code differs from mode and did not move this cycle
	assign db_run = (sw_q != mode) && (sw_q == sw_sync);

	////////////////////////////////////////
	// Debounce
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			db_cnt   <= '0;
			accept   <= 1'b0;
			code_acc <= `MODE_VGA;
		end else begin
			accept <= 1'b0;
			if (!db_run) begin
				db_cnt <= '0;                              // Any glitch starts over
			end else if (db_cnt == DB_W'(`DEBOUNCE_CYCLES - 1)) begin
				db_cnt   <= '0;
				accept   <= 1'b1;
				code_acc <= sw_q;
			end else begin
				db_cnt <= db_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Mode and threshold registers
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or negedge arst_n) begin
		if (!arst_n) begin
			mode    <= `MODE_VGA;
			timing  <= mode_timing(`MODE_VGA);
			restart <= 1'b0;
		end else begin
			restart <= accept;                            // Same edge as new thresholds
			if (accept) begin
				mode   <= code_acc;
				timing <= mode_timing(code_acc);          // Table lookup
			end
		end
	end

	// Raster restarts whenever the mode moves
	a_mode_with_restart : assert property (
		@(posedge clk50m_bufg) disable iff (!arst_n)
		(mode != $past(mode)) |-> $rose(restart)
	);

endmodule

/* source/video_pkg.sv */
`include "video_settings.svh"

package video_pkg;

	typedef logic [3:0] mode_code_t;   // Raw switch code

	// Thresholds the raster counter compares against
	typedef struct packed {
		logic [`CNT_W-1:0] h_act_last;   // Last visible pixel
		logic [`CNT_W-1:0] h_sync_start; // First hsync pixel
		logic [`CNT_W-1:0] h_sync_stop;  // One past last hsync pixel
		logic [`CNT_W-1:0] h_last;       // Last pixel of the line
		logic [`CNT_W-1:0] v_act_last;   // Last visible line
		logic [`CNT_W-1:0] v_sync_start;
		logic [`CNT_W-1:0] v_sync_stop;
		logic [`CNT_W-1:0] v_last;       // Last line of the frame
		logic              neg_pol;      // 1 means active-low sync
	} raster_timing_t;

	// Running sums of pixels and porches
	function automatic raster_timing_t build_timing(
		input int   h_pix,
		input int   h_fp,
		input int   h_sw,
		input int   h_bp,
		input int   v_pix,
		input int   v_fp,
		input int   v_sw,
		input int   v_bp,
		input logic neg
	);
		raster_timing_t t;
		t.h_act_last   = `CNT_W'(h_pix - 1);
		t.h_sync_start = `CNT_W'(h_pix - 1 + h_fp);
		t.h_sync_stop  = `CNT_W'(h_pix - 1 + h_fp + h_sw);
		t.h_last       = `CNT_W'(h_pix - 1 + h_fp + h_sw + h_bp);
		t.v_act_last   = `CNT_W'(v_pix - 1);
		t.v_sync_start = `CNT_W'(v_pix - 1 + v_fp);
		t.v_sync_stop  = `CNT_W'(v_pix - 1 + v_fp + v_sw);
		t.v_last       = `CNT_W'(v_pix - 1 + v_fp + v_sw + v_bp);
		t.neg_pol      = neg;
		return t;
	endfunction

	// Mode table
	function automatic raster_timing_t mode_timing(input mode_code_t code);
		raster_timing_t t;
		case (code)
			`MODE_VGA: t = build_timing(`H_PIXELS_VGA, `H_FPORCH_VGA, `H_SYNC_VGA,
				`H_BPORCH_VGA, `V_LINES_VGA, `V_FPORCH_VGA, `V_SYNC_VGA,
				`V_BPORCH_VGA, `POL_NEG_VGA);
			`MODE_SVGA: t = build_timing(`H_PIXELS_SVGA, `H_FPORCH_SVGA, `H_SYNC_SVGA,
				`H_BPORCH_SVGA, `V_LINES_SVGA, `V_FPORCH_SVGA, `V_SYNC_SVGA,
				`V_BPORCH_SVGA, `POL_NEG_SVGA);
			`MODE_XGA: t = build_timing(`H_PIXELS_XGA, `H_FPORCH_XGA, `H_SYNC_XGA,
				`H_BPORCH_XGA, `V_LINES_XGA, `V_FPORCH_XGA, `V_SYNC_XGA,
				`V_BPORCH_XGA, `POL_NEG_XGA);
			`MODE_SXGA: t = build_timing(`H_PIXELS_SXGA, `H_FPORCH_SXGA, `H_SYNC_SXGA,
				`H_BPORCH_SXGA, `V_LINES_SXGA, `V_FPORCH_SXGA, `V_SYNC_SXGA,
				`V_BPORCH_SXGA, `POL_NEG_SXGA);
			`MODE_CAMERA: t = build_timing(`H_PIXELS_CAMERA, `H_FPORCH_CAMERA,
				`H_SYNC_CAMERA, `H_BPORCH_CAMERA, `V_LINES_CAMERA, `V_FPORCH_CAMERA,
				`V_SYNC_CAMERA, `V_BPORCH_CAMERA, `POL_NEG_CAMERA);
			default: t = build_timing(`H_PIXELS_HD720, `H_FPORCH_HD720, `H_SYNC_HD720,
				`H_BPORCH_HD720, `V_LINES_HD720, `V_FPORCH_HD720, `V_SYNC_HD720,
				`V_BPORCH_HD720, `POL_NEG_HD720);   // 720p and any unlisted code
		endcase
		return t;
	endfunction

endpackage

/* source/video_settings.svh */
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

////////////////////////////////////////
// Mode switch codes
////////////////////////////////////////
`define MODE_VGA        4'b0000
`define MODE_SVGA       4'b0001
`define MODE_XGA        4'b0011
`define MODE_HD720      4'b0010   // Also the fallback for unlisted codes
`define MODE_SXGA       4'b1000
`define MODE_CAMERA     4'b1001

// Raster counter width that covers 1688 total pixels
`define CNT_W           11

// Stable cycles before a new code is taken
`define DEBOUNCE_CYCLES 16

////////////////////////////////////////
// Per-mode raster values
////////////////////////////////////////
// 640x480
`define H_PIXELS_VGA    640
`define H_FPORCH_VGA    16
`define H_SYNC_VGA      96
`define H_BPORCH_VGA    48
`define V_LINES_VGA     480
`define V_FPORCH_VGA    11
`define V_SYNC_VGA      2
`define V_BPORCH_VGA    31
`define POL_NEG_VGA     1'b1

// 800x600
`define H_PIXELS_SVGA   800
`define H_FPORCH_SVGA   40
`define H_SYNC_SVGA     128
`define H_BPORCH_SVGA   88
`define V_LINES_SVGA    600
`define V_FPORCH_SVGA   1
`define V_SYNC_SVGA     4
`define V_BPORCH_SVGA   23
`define POL_NEG_SVGA    1'b0

// 1024x768
`define H_PIXELS_XGA    1024
`define H_FPORCH_XGA    24
`define H_SYNC_XGA      136
`define H_BPORCH_XGA    160
`define V_LINES_XGA     768
`define V_FPORCH_XGA    3
`define V_SYNC_XGA      6
`define V_BPORCH_XGA    29
`define POL_NEG_XGA     1'b1

// 1280x720
`define H_PIXELS_HD720  1280
`define H_FPORCH_HD720  110
`define H_SYNC_HD720    40
`define H_BPORCH_HD720  220
`define V_LINES_HD720   720
`define V_FPORCH_HD720  5
`define V_SYNC_HD720    5
`define V_BPORCH_HD720  20
`define POL_NEG_HD720   1'b0

// 1280x1024
`define H_PIXELS_SXGA   1280
`define H_FPORCH_SXGA   48
`define H_SYNC_SXGA     112
`define H_BPORCH_SXGA   248
`define V_LINES_SXGA    1024
`define V_FPORCH_SXGA   1
`define V_SYNC_SXGA     3
`define V_BPORCH_SXGA   38
`define POL_NEG_SXGA    1'b0

// Camera format is 720p with trimmed sync
`define H_PIXELS_CAMERA 1280
`define H_FPORCH_CAMERA 110
`define H_SYNC_CAMERA   39
`define H_BPORCH_CAMERA 220
`define V_LINES_CAMERA  720
`define V_FPORCH_CAMERA 4
`define V_SYNC_CAMERA   4
`define V_BPORCH_CAMERA 22
`define POL_NEG_CAMERA  1'b0

`endif
